//--- project.f
source/mma_pkg.sv
source/mma_weight_bank.sv
source/mma_operand_offset.sv
source/mma_mac_array.sv
source/mma_requant.sv
source/mma_top.sv
verification/mma_tb.sv

//--- Makefile
# Verilator flow for the int8 matrix-vector engine
VERILATOR  ?= verilator
TOP        ?= mma_tb
LINT_TOP   ?= $(TOP)
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing -Wno-fatal
SOURCES    := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "no result found in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/mma_tb.sv
`default_nettype none
`timescale 1ns/100ps

module mma_tb import mma_pkg::*; ();

    localparam int LANES = 4;

    typedef out_t [LANES-1:0] res_vec_t;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               wt_load;
    wt_row_t            wt_row;
    wgt_t [LANES-1:0]   wt_data;
    logic               in_valid;
    act_t [LANES-1:0]   in_vec;
    zp_t                lhs_zp;
    zp_t                rhs_zp;
    quant_cfg_t         cfg;
    logic               out_valid;
    res_vec_t           out_vec;

    wgt_t       sh_w [LANES][LANES];  // Raw weights, zero point added in the model
    acc_t       sh_b [LANES];
    res_vec_t   exp_q[$];
    int         stamp_q[$];           // Cycle in which each strobe rose

    integer     seed = 32'h916b;
    int         cyc = 0;
    string      test_name = "reset";
    int         test_err = 0;
    int         test_chk = 0;
    int         err_cnt = 0;
    int         chk_cnt = 0;
    int         test_cnt = 0;
    bit         seen_lo = 1'b0;
    bit         seen_hi = 1'b0;

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    mma_top #(
        .LANES(LANES)
    ) mma_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .wt_load  (wt_load),
        .wt_row   (wt_row),
        .wt_data  (wt_data),
        .in_valid (in_valid),
        .in_vec   (in_vec),
        .lhs_zp   (lhs_zp),
        .rhs_zp   (rhs_zp),
        .cfg      (cfg),
        .out_valid(out_valid),
        .out_vec  (out_vec)
    );

    // ==================================================
    // Reference model
    // ==================================================
    function automatic res_vec_t ref_vec(input act_t [LANES-1:0] a);
        res_vec_t res;
        int       acc;
        longint   prod;
        longint   rnd;
        int       sh;
        int       v;
        for (int j = 0; j < LANES; j++) begin
            acc = sh_b[j];
            for (int i = 0; i < LANES; i++) begin
                acc += (int'(a[i]) + int'(lhs_zp)) * (int'(sh_w[j][i]) + int'(rhs_zp));
            end
            prod = longint'(acc) * longint'(cfg.q_mult);
            sh   = FRAC_BITS + int'(cfg.q_shift);
            rnd  = (prod + (64'sd1 <<< (sh - 1))) >>> sh;  // Round half up
            v    = int'(rnd) + cfg.dst_zp;
            if (v < int'(cfg.act_min)) begin
                res[j] = cfg.act_min;
            end else if (v > int'(cfg.act_max)) begin
                res[j] = cfg.act_max;
            end else begin
                res[j] = out_t'(v);
            end
        end
        return res;
    endfunction

    function automatic quant_cfg_t make_cfg(input acc_t qm, input int qs, input int dzp,
                                            input int lo, input int hi);
        quant_cfg_t c;
        c.q_mult  = qm;
        c.q_shift = 5'(qs);
        c.dst_zp  = acc_t'(dzp);
        c.act_min = out_t'(lo);
        c.act_max = out_t'(hi);
        return c;
    endfunction

    function automatic act_t [LANES-1:0] rand_vec();
        act_t [LANES-1:0] v;
        for (int i = 0; i < LANES; i++) begin
            v[i] = act_t'($random(seed));
        end
        return v;
    endfunction

    function automatic void note_error();
        err_cnt++;
        test_err++;
    endfunction

    // ==================================================
    // Stimulus tasks
    // ==================================================
    task automatic set_quant(input zp_t lzp, input zp_t rzp, input quant_cfg_t c);
        @(posedge clk);
        lhs_zp <= lzp;
        rhs_zp <= rzp;
        cfg    <= c;
    endtask

    task automatic write_row(input int row, input acc_t bias, input wgt_t [LANES-1:0] w);
        @(posedge clk);
        wt_load     <= 1'b1;
        wt_row.row  <= 8'(row);
        wt_row.bias <= bias;
        wt_data     <= w;
        for (int i = 0; i < LANES; i++) begin
            sh_w[row][i] = w[i];
        end
        sh_b[row] = bias;
        @(posedge clk);
        wt_load <= 1'b0;
    endtask

    task automatic send_vec(input act_t [LANES-1:0] v);
        @(posedge clk);
        in_valid <= 1'b1;
        in_vec   <= v;
        exp_q.push_back(ref_vec(v));
        stamp_q.push_back(cyc + 1);
    endtask

    task automatic stop_stream();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 200) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout in %s: %0d results never arrived", test_name, exp_q.size());
            note_error();
            exp_q.delete();
            stamp_q.delete();
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err  = 0;
        test_chk  = 0;
        seen_lo   = 1'b0;
        seen_hi   = 1'b0;
    endtask

    task automatic end_test();
        drain();
        test_cnt++;
        $display("test %s: %0d checks, %0d errors", test_name, test_chk, test_err);
    endtask

    task automatic load_random_rows(input int bias_mod);
        for (int j = 0; j < LANES; j++) begin
            if (bias_mod == 0) begin
                write_row(j, $random(seed), rand_vec());  // Full 32-bit bias
            end else begin
                write_row(j, $random(seed) % bias_mod, rand_vec());
            end
        end
    endtask

    // ==================================================
    // Compare results
    // ==================================================
    always @(negedge clk) begin : compare
        res_vec_t exp_v;
        int       stamp;
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("%s: out_valid high with no vector pending", test_name);
                note_error();
            end else begin
                exp_v = exp_q.pop_front();
                stamp = stamp_q.pop_front();
                test_chk++;
                chk_cnt++;
                if (out_vec !== exp_v) begin
                    $display("mismatch %s: expected %h actual %h", test_name, exp_v, out_vec);
                    note_error();
                end
                if (cyc - stamp != PIPE_LATENCY) begin
                    $display("%s: result came %0d cycles after its input instead of %0d",
                             test_name, cyc - stamp, PIPE_LATENCY);
                    note_error();
                end
                for (int j = 0; j < LANES; j++) begin
                    if (out_vec[j] == cfg.act_min) seen_lo = 1'b1;
                    if (out_vec[j] == cfg.act_max) seen_hi = 1'b1;
                end
            end
        end
    end

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        act_t [LANES-1:0] v;
        wgt_t [LANES-1:0] w;
        acc_t             qm;

        rst_n    = 1'b0;
        wt_load  = 1'b0;
        wt_row   = '0;
        wt_data  = '0;
        in_valid = 1'b0;
        in_vec   = '0;
        lhs_zp   = '0;
        rhs_zp   = '0;
        cfg      = make_cfg(32'sh4000_0000, 0, 0, -128, 127);
        for (int j = 0; j < LANES; j++) begin
            sh_b[j] = '0;
            for (int i = 0; i < LANES; i++) begin
                sh_w[j][i] = '0;
            end
        end

        start_test("reset");
        repeat (4) begin
            @(negedge clk);
            test_chk++;
            chk_cnt++;
            if (out_valid !== 1'b0) begin
                $display("reset: out_valid is not low while rst_n is asserted");
                note_error();
            end
        end
        @(posedge clk);
        rst_n <= 1'b1;
        repeat (8) begin
            @(negedge clk);
            test_chk++;
            chk_cnt++;
            if (out_valid !== 1'b0) begin
                $display("reset: out_valid rose with no input given");
                note_error();
            end
        end
        end_test();

        // Identity weights, result is a/2 rounded
        start_test("identity");
        set_quant('0, '0, make_cfg(32'sh4000_0000, 0, 0, -128, 127));
        for (int j = 0; j < LANES; j++) begin
            w    = '0;
            w[j] = 8'sd1;
            write_row(j, 0, w);
        end
        for (int k = 0; k < 8; k++) begin
            v = (k == 0) ? {act_t'(-128), act_t'(-1), act_t'(3), act_t'(127)} : rand_vec();
            send_vec(v);
            stop_stream();
            drain();
        end
        end_test();

        start_test("stream");
        qm = 32'h0008_0000 + ($random(seed) & 32'h000f_ffff);
        set_quant(zp_t'($random(seed)), zp_t'($random(seed)),
                  make_cfg(qm, $random(seed) & 3, $random(seed) % 16, -128, 127));
        load_random_rows(4096);
        repeat (200) send_vec(rand_vec());
        stop_stream();
        end_test();

        // Every shift, with extreme and random multipliers
        start_test("requant");
        for (int s = 0; s < 32; s++) begin
            qm = $random(seed);
            if (s % 3 == 0) qm = 32'sh7fff_ffff;
            else if (s % 3 == 1) qm = 32'sh8000_0000;
            set_quant('0, '0, make_cfg(qm, s, 0, -128, 127));
            load_random_rows(0);
            repeat (6) send_vec(rand_vec());
            stop_stream();
            drain();
        end
        end_test();

        start_test("clamp");
        set_quant('0, '0, make_cfg(32'sh4000_0000, 8, 3, -10, 12));
        load_random_rows(20000);
        repeat (40) send_vec(rand_vec());
        stop_stream();
        drain();
        if (!(seen_lo && seen_hi)) begin
            $display("clamp: results did not saturate at both ends of the range");
            note_error();
        end
        end_test();

        // Row 2 rewritten while the first burst is still in flight
        start_test("reload");
        set_quant(zp_t'($random(seed)), zp_t'($random(seed)),
                  make_cfg(32'h0010_0000, 1, 0, -128, 127));
        load_random_rows(50000);
        repeat (20) send_vec(rand_vec());
        stop_stream();
        write_row(2, $random(seed) % 50000, rand_vec());
        repeat (20) send_vec(rand_vec());
        stop_stream();
        end_test();

        $display("summary: %0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/mma_top.sv
`default_nettype none
`timescale 1ns/100ps

module mma_top import mma_pkg::*; #(
    parameter int unsigned LANES = 4   // Output channels and inputs per vector
) (
    // ==================================================
    // Clock and reset
    // ==================================================
    input  logic                 clk,
    input  logic                 rst_n,

    // ==================================================
    // Weight row load
    // ==================================================
    input  logic                 wt_load,
    input  wt_row_t              wt_row,
    input  wgt_t  [LANES-1:0]    wt_data,

    // ==================================================
    // Activation stream
    // ==================================================
    input  logic                 in_valid,
    input  act_t  [LANES-1:0]    in_vec,

    // Quantization levels
    input  zp_t                  lhs_zp,
    input  zp_t                  rhs_zp,
    input  quant_cfg_t           cfg,

    // ==================================================
    // Result stream
    // ==================================================
    output logic                 out_valid,  // PIPE_LATENCY after in_valid
    output out_t  [LANES-1:0]    out_vec
);

    opnd_t [LANES-1:0][LANES-1:0]   weights;
    acc_t  [LANES-1:0]              biases;

    logic                           s1_valid;
    opnd_t [LANES-1:0]              s1_vec;

    logic                           s2_valid;
    acc_t  [LANES-1:0]              s2_acc;

    // Weight and bias storage
    mma_weight_bank #(
        .LANES(LANES)
    ) u_weight_bank (
        .clk    (clk),
        .rst_n  (rst_n),
        .wt_load(wt_load),
        .wt_row (wt_row),
        .wt_data(wt_data),
        .rhs_zp (rhs_zp),
        .weights(weights),
        .biases (biases)
    );

    // 1 cycle
    mma_operand_offset #(
        .LANES(LANES)
    ) u_operand_offset (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_valid(in_valid),
        .in_vec  (in_vec),
        .lhs_zp  (lhs_zp),
        .s1_valid(s1_valid),
        .s1_vec  (s1_vec)
    );

    // 2 cycles
    mma_mac_array #(
        .LANES(LANES)
    ) u_mac_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .s1_valid(s1_valid),
        .s1_vec  (s1_vec),
        .weights (weights),
        .biases  (biases),
        .s2_valid(s2_valid),
        .s2_acc  (s2_acc)
    );

    // 2 cycles
    mma_requant #(
        .LANES(LANES)
    ) u_requant (
        .clk      (clk),
        .rst_n    (rst_n),
        .s2_valid (s2_valid),
        .s2_acc   (s2_acc),
        .cfg      (cfg),
        .out_valid(out_valid),
        .out_vec  (out_vec)
    );

endmodule

`default_nettype wire

//--- source/mma_requant.sv
`default_nettype none
`timescale 1ns/100ps

module mma_requant import mma_pkg::*; #(
    parameter int unsigned LANES = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 s2_valid,
    input  acc_t  [LANES-1:0]    s2_acc,
    input  quant_cfg_t           cfg,      // Held stable while busy

    output logic                 out_valid,
    output out_t  [LANES-1:0]    out_vec
);

    logic                    q1_valid;
    qprod_t [LANES-1:0]      q1_prod;
    logic   [5:0]            tot_shift;   // FRAC_BITS + q_shift, 31..62
    qprod_t                  round_add;
    out_t   [LANES-1:0]      clamp_vec;

    // ==================================================
    // Valid pipe
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            q1_valid  <= s2_valid;
            out_valid <= q1_valid;
        end
    end

    // ==================================================
    // Stage A: 64-bit multiply
    // ==================================================
    always_ff @(posedge clk) begin
        if (s2_valid) begin
            for (int j = 0; j < LANES; j++) begin
                q1_prod[j] <= qprod_t'(s2_acc[j]) * qprod_t'(cfg.q_mult);
            end
        end
    end

    // ==================================================
    // Stage B: round, shift, offset, clamp
    // ==================================================
    assign tot_shift = 6'(FRAC_BITS) + 6'(cfg.q_shift);
    assign round_add = qprod_t'(1) <<< (tot_shift - 6'd1);  // Half LSB

    always_comb begin
        qprod_t rnd_sum;
        acc_t   scaled;
        acc_t   shifted_zp;

        for (int j = 0; j < LANES; j++) begin
            rnd_sum    = q1_prod[j] + round_add;  // |p| <= 2^62, no overflow
            scaled     = acc_t'(rnd_sum >>> tot_shift);
            shifted_zp = scaled + cfg.dst_zp;

            // Saturate to the activation range
            if (shifted_zp < acc_t'(cfg.act_min)) begin
                clamp_vec[j] = cfg.act_min;
            end else if (shifted_zp > acc_t'(cfg.act_max)) begin
                clamp_vec[j] = cfg.act_max;
            end else begin
                clamp_vec[j] = out_t'(shifted_zp);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (q1_valid) begin
            out_vec <= clamp_vec;
        end
    end

endmodule

`default_nettype wire

//--- source/mma_mac_array.sv
`default_nettype none
`timescale 1ns/100ps

module mma_mac_array import mma_pkg::*; #(
    parameter int unsigned LANES = 4
) (
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic                            s1_valid,
    input  opnd_t [LANES-1:0]               s1_vec,   // Offset activations
    input  opnd_t [LANES-1:0][LANES-1:0]    weights,  // [channel][lane]
    input  acc_t  [LANES-1:0]               biases,

    output logic                            s2_valid,
    output acc_t  [LANES-1:0]               s2_acc
);

    logic                           p1_valid;
    mul_t  [LANES-1:0][LANES-1:0]   p1_prod;   // [channel][lane]
    acc_t  [LANES-1:0]              p1_bias;
    acc_t  [LANES-1:0]              acc_sum;

    // ==================================================
    // Valid pipe
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            p1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            p1_valid <= s1_valid;
            s2_valid <= p1_valid;
        end
    end

    // ==================================================
    // Stage A: products
    // ==================================================

    // Bias is sampled together with the weights so that a row write
    // never splits across one vector
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            for (int j = 0; j < LANES; j++) begin
                for (int i = 0; i < LANES; i++) begin
                    p1_prod[j][i] <= mul_t'(s1_vec[i]) * mul_t'(weights[j][i]);
                end
                p1_bias[j] <= biases[j];
            end
        end
    end

    // ==================================================
    // Stage B: channel sums plus bias
    // ==================================================
    always_comb begin
        for (int j = 0; j < LANES; j++) begin
            acc_sum[j] = p1_bias[j];
            for (int i = 0; i < LANES; i++) begin
                acc_sum[j] = acc_sum[j] + acc_t'(p1_prod[j][i]);  // 32-bit wrap
            end
        end
    end

    always_ff @(posedge clk) begin
        if (p1_valid) begin
            s2_acc <= acc_sum;
        end
    end

endmodule

`default_nettype wire

//--- source/mma_operand_offset.sv
`default_nettype none
`timescale 1ns/100ps

module mma_operand_offset import mma_pkg::*; #(
    parameter int unsigned LANES = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 in_valid,  // One vector per strobe
    input  act_t  [LANES-1:0]    in_vec,
    input  zp_t                  lhs_zp,    // Activation zero point

    output logic                 s1_valid,
    output opnd_t [LANES-1:0]    s1_vec
);

    // ==================================================
    // Stage 1 valid
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    // ==================================================
    // Stage 1 data
    // ==================================================

    // Range is -384..382, fits opnd_t
    always_ff @(posedge clk) begin
        if (in_valid) begin
            for (int i = 0; i < LANES; i++) begin
                s1_vec[i] <= opnd_t'(in_vec[i]) + opnd_t'(lhs_zp);
            end
        end
    end

endmodule

`default_nettype wire

//--- source/mma_weight_bank.sv
`default_nettype none
`timescale 1ns/100ps

module mma_weight_bank import mma_pkg::*; #(
    parameter int unsigned LANES = 4
) (
    input  logic                                clk,
    input  logic                                rst_n,

    input  logic                                wt_load,  // Row write strobe
    input  wt_row_t                             wt_row,
    input  wgt_t  [LANES-1:0]                   wt_data,
    input  zp_t                                 rhs_zp,

    output opnd_t [LANES-1:0][LANES-1:0]        weights,  // [channel][lane]
    output acc_t  [LANES-1:0]                   biases
);

    localparam int unsigned ROW_W = (LANES > 1) ? $clog2(LANES) : 1;

    logic [ROW_W-1:0] row_idx;

    assign row_idx = wt_row.row[ROW_W-1:0];

    // ==================================================
    // Row storage
    // ==================================================

    // The weight zero point is folded in here so the MAC path only
    // sees ready operands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weights <= '0;
            biases  <= '0;
        end else if (wt_load) begin
            for (int i = 0; i < LANES; i++) begin
                weights[row_idx][i] <= opnd_t'(wt_data[i]) + opnd_t'(rhs_zp);
            end
            biases[row_idx] <= wt_row.bias;  // Bias goes with its row
        end
    end

endmodule

`default_nettype wire

//--- source/mma_pkg.sv
`default_nettype none

package mma_pkg;

    // ==================================================
    // Scalar types
    // ==================================================
    typedef logic signed [7:0]  act_t;    // Activation element
    typedef logic signed [7:0]  wgt_t;    // Weight element
    typedef logic signed [8:0]  zp_t;     // Input zero point
    typedef logic signed [9:0]  opnd_t;   // Operand with zero point applied
    typedef logic signed [19:0] mul_t;    // opnd_t x opnd_t product
    typedef logic signed [31:0] acc_t;    // Accumulator and bias
    typedef logic signed [63:0] qprod_t;  // Accumulator x q_mult
    typedef logic signed [7:0]  out_t;    // Requantized result

    // ==================================================
    // Config structs
    // ==================================================

    // Per-tensor requantization
    typedef struct packed {
        acc_t        q_mult;   // Q0.31 multiplier
        logic [4:0]  q_shift;  // Extra right shift
        acc_t        dst_zp;   // Output zero point
        out_t        act_min;  // Lower clamp
        out_t        act_max;  // Upper clamp
    } quant_cfg_t;

    // One weight row write
    typedef struct packed {
        logic [7:0] row;   // Low bits select the output channel
        acc_t       bias;
    } wt_row_t;

    // ==================================================
    // Fixed-point constants
    // ==================================================
    localparam int FRAC_BITS    = 31;  // Fraction width of q_mult
    localparam int PIPE_LATENCY = 5;   // in_valid to out_valid

endpackage

`default_nettype wire
